/* common/iq_pkg.sv */
package iq_pkg;

    // Queue geometry
    localparam int IQ_DEPTH = 8;
    localparam int SLOT_W   = 3;    // clog2 of IQ_DEPTH

    // Datapath widths
    localparam int TAG_W    = 6;    // Physical register tag
    localparam int UOP_W    = 16;   // Opaque micro-op payload

    // Index of one queue entry
    typedef logic [SLOT_W-1:0]   slot_idx_t;

    // Source or destination register tag
    typedef logic [TAG_W-1:0]    preg_tag_t;

    // Micro-op payload, never decoded here
    typedef logic [UOP_W-1:0]    uop_t;

    // One bit per entry
    typedef logic [IQ_DEPTH-1:0] slot_vec_t;

endpackage

/* src/pick1_priority_bin.sv */
`timescale 1ns/1ps

module pick1_priority_bin #(
    parameter int INPUT_COUNT          = 2,
    parameter bit PRIORITY_LOWER_FIRST = 1
) (
    input  logic [INPUT_COUNT-1:0]         dvalid,
    output logic [$clog2(INPUT_COUNT)-1:0] qaddr,
    output logic                           qvalid
);

    localparam int ADDR_W  = $clog2(INPUT_COUNT);
    localparam int P_COUNT = 1 << ADDR_W;       // Inputs padded to a power of two
    localparam int NODES   = 2 * P_COUNT - 1;

    // Heap-ordered tree with node 0 at the root
    wire [ADDR_W-1:0] node_addr  [NODES];
    wire              node_valid [NODES];

    // Leaves carry their own index
    for (genvar i = 0; i < P_COUNT; i++) begin : g_leaf
        if (i < INPUT_COUNT) begin : g_real
            assign node_addr[P_COUNT-1+i]  = ADDR_W'(i);
            assign node_valid[P_COUNT-1+i] = dvalid[i];
        end else begin : g_pad
            assign node_addr[P_COUNT-1+i]  = '0;
            assign node_valid[P_COUNT-1+i] = 1'b0;
        end
    end

    for (genvar lv = 0; lv < ADDR_W; lv++) begin : g_level
        for (genvar n = 0; n < (1 << lv); n++) begin : g_node
            localparam int PARENT = (1 << lv) - 1 + n;
            localparam int LEFT   = 2 * PARENT + 1;    // Lower half of the range
            localparam int RIGHT  = 2 * PARENT + 2;

            logic take_left;

            // Lowest-first prefers the left child and highest-first the right one
            if (PRIORITY_LOWER_FIRST) begin : g_lf
                assign take_left = node_valid[LEFT];
            end else begin : g_hf
                assign take_left = !node_valid[RIGHT];
            end

            assign node_addr[PARENT]  = take_left ? node_addr[LEFT] : node_addr[RIGHT];
            assign node_valid[PARENT] = node_valid[LEFT] | node_valid[RIGHT];
        end
    end

    assign qaddr  = node_addr[0];
    assign qvalid = node_valid[0];

endmodule

/* issue_queue/iq_entry_array.sv */
`timescale 1ns/1ps

module iq_entry_array (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               dispatch_valid,
    input  iq_pkg::uop_t       dispatch_uop,
    input  iq_pkg::preg_tag_t  dispatch_dst,
    input  iq_pkg::preg_tag_t  dispatch_src1,
    input  logic               dispatch_src1_ready,
    input  iq_pkg::preg_tag_t  dispatch_src2,
    input  logic               dispatch_src2_ready,

    input  iq_pkg::slot_idx_t  alloc_slot,
    input  logic               alloc_any,

    input  logic               wakeup_valid,
    input  iq_pkg::preg_tag_t  wakeup_tag,

    input  logic               grant_valid,
    input  iq_pkg::slot_idx_t  grant_slot,

    output iq_pkg::slot_vec_t  free_mask,
    output iq_pkg::slot_vec_t  req_mask,
    output iq_pkg::uop_t       entry_uop [iq_pkg::IQ_DEPTH],
    output iq_pkg::preg_tag_t  entry_dst [iq_pkg::IQ_DEPTH]
);

    // Per-entry control state
    iq_pkg::slot_vec_t  valid_q;
    iq_pkg::slot_vec_t  src1_rdy_q;
    iq_pkg::slot_vec_t  src2_rdy_q;

    // Per-entry payload
    iq_pkg::preg_tag_t  src1_tag_q [iq_pkg::IQ_DEPTH];
    iq_pkg::preg_tag_t  src2_tag_q [iq_pkg::IQ_DEPTH];
    iq_pkg::uop_t       uop_q      [iq_pkg::IQ_DEPTH];
    iq_pkg::preg_tag_t  dst_q      [iq_pkg::IQ_DEPTH];

    iq_pkg::slot_vec_t  wr_mask;
    iq_pkg::slot_vec_t  rel_mask;
    iq_pkg::slot_vec_t  wake1;
    iq_pkg::slot_vec_t  wake2;
    logic               disp_wr;
    logic               disp_rdy1;
    logic               disp_rdy2;

    assign disp_wr = dispatch_valid & alloc_any;    // Dropped when full

    // Same-cycle broadcast also wakes the incoming uop
    assign disp_rdy1 = dispatch_src1_ready | (wakeup_valid && dispatch_src1 == wakeup_tag);
    assign disp_rdy2 = dispatch_src2_ready | (wakeup_valid && dispatch_src2 == wakeup_tag);

    always_comb begin
        for (int i = 0; i < iq_pkg::IQ_DEPTH; i++) begin
            wr_mask[i]  = disp_wr && alloc_slot == iq_pkg::slot_idx_t'(i);
            rel_mask[i] = grant_valid && grant_slot == iq_pkg::slot_idx_t'(i);
            wake1[i]    = wakeup_valid && valid_q[i] && src1_tag_q[i] == wakeup_tag;
            wake2[i]    = wakeup_valid && valid_q[i] && src2_tag_q[i] == wakeup_tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q    <= '0;
            src1_rdy_q <= '0;
            src2_rdy_q <= '0;
        end else begin
            for (int i = 0; i < iq_pkg::IQ_DEPTH; i++) begin
                if (wr_mask[i]) begin
                    valid_q[i]    <= 1'b1;
                    src1_rdy_q[i] <= disp_rdy1;
                    src2_rdy_q[i] <= disp_rdy2;
                end else begin
                    if (rel_mask[i]) begin
                        valid_q[i] <= 1'b0;    // Issued this edge
                    end
                    if (wake1[i]) begin
                        src1_rdy_q[i] <= 1'b1;
                    end
                    if (wake2[i]) begin
                        src2_rdy_q[i] <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < iq_pkg::IQ_DEPTH; i++) begin
            if (wr_mask[i]) begin
                src1_tag_q[i] <= dispatch_src1;
                src2_tag_q[i] <= dispatch_src2;
                uop_q[i]      <= dispatch_uop;
                dst_q[i]      <= dispatch_dst;
            end
        end
    end

    assign free_mask = ~valid_q;
    assign req_mask  = valid_q & src1_rdy_q & src2_rdy_q;   // Both operands ready

    // Flat read ports for the select mux
    assign entry_uop = uop_q;
    assign entry_dst = dst_q;

endmodule

/* issue_queue/iq_select.sv */
`timescale 1ns/1ps

module iq_select (
    input  logic               clk,
    input  logic               rst_n,

    input  iq_pkg::slot_vec_t  req_mask,
    input  iq_pkg::uop_t       entry_uop [iq_pkg::IQ_DEPTH],
    input  iq_pkg::preg_tag_t  entry_dst [iq_pkg::IQ_DEPTH],
    input  logic               issue_stall,

    output logic               grant_valid,
    output iq_pkg::slot_idx_t  grant_slot,

    output logic               issue_valid,
    output iq_pkg::slot_idx_t  issue_slot,
    output iq_pkg::uop_t       issue_uop,
    output iq_pkg::preg_tag_t  issue_dst
);

    iq_pkg::slot_vec_t  req_live;

    // Stall hides every request, so nothing is granted or released
    assign req_live = issue_stall ? '0 : req_mask;

    // Highest ready index wins
    pick1_priority_bin #(
        .INPUT_COUNT          (iq_pkg::IQ_DEPTH),
        .PRIORITY_LOWER_FIRST (0)
    ) u_pick_issue (
        .dvalid (req_live),
        .qaddr  (grant_slot),
        .qvalid (grant_valid)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= grant_valid;
        end
    end

    // Payload captured at the same edge that frees the entry
    always_ff @(posedge clk) begin
        if (grant_valid) begin
            issue_slot <= grant_slot;
            issue_uop  <= entry_uop[grant_slot];
            issue_dst  <= entry_dst[grant_slot];
        end
    end

endmodule

/* src/issue_queue_top.sv */
`timescale 1ns/1ps

module issue_queue_top (
    input  logic               clk,
    input  logic               rst_n,

    // Dispatch
    input  logic               dispatch_valid,
    input  iq_pkg::uop_t       dispatch_uop,
    input  iq_pkg::preg_tag_t  dispatch_dst,
    input  iq_pkg::preg_tag_t  dispatch_src1,
    input  logic               dispatch_src1_ready,
    input  iq_pkg::preg_tag_t  dispatch_src2,
    input  logic               dispatch_src2_ready,
    output logic               full,

    // Wakeup broadcast
    input  logic               wakeup_valid,
    input  iq_pkg::preg_tag_t  wakeup_tag,

    input  logic               issue_stall,

    // Issue port
    output logic               issue_valid,
    output iq_pkg::slot_idx_t  issue_slot,
    output iq_pkg::uop_t       issue_uop,
    output iq_pkg::preg_tag_t  issue_dst
);

    iq_pkg::slot_vec_t  free_mask;
    iq_pkg::slot_vec_t  req_mask;
    iq_pkg::slot_idx_t  alloc_slot;
    logic               alloc_any;
    logic               grant_valid;
    iq_pkg::slot_idx_t  grant_slot;
    iq_pkg::uop_t       entry_uop [iq_pkg::IQ_DEPTH];
    iq_pkg::preg_tag_t  entry_dst [iq_pkg::IQ_DEPTH];

    // Lowest free slot takes the next dispatch
    pick1_priority_bin #(
        .INPUT_COUNT          (iq_pkg::IQ_DEPTH),
        .PRIORITY_LOWER_FIRST (1)
    ) u_pick_alloc (
        .dvalid (free_mask),
        .qaddr  (alloc_slot),
        .qvalid (alloc_any)
    );

    assign full = ~alloc_any;

    iq_entry_array u_entries (
        .clk                 (clk),
        .rst_n               (rst_n),
        .dispatch_valid      (dispatch_valid),
        .dispatch_uop        (dispatch_uop),
        .dispatch_dst        (dispatch_dst),
        .dispatch_src1       (dispatch_src1),
        .dispatch_src1_ready (dispatch_src1_ready),
        .dispatch_src2       (dispatch_src2),
        .dispatch_src2_ready (dispatch_src2_ready),
        .alloc_slot          (alloc_slot),
        .alloc_any           (alloc_any),
        .wakeup_valid        (wakeup_valid),
        .wakeup_tag          (wakeup_tag),
        .grant_valid         (grant_valid),
        .grant_slot          (grant_slot),
        .free_mask           (free_mask),
        .req_mask            (req_mask),
        .entry_uop           (entry_uop),
        .entry_dst           (entry_dst)
    );

    iq_select u_select (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_mask    (req_mask),
        .entry_uop   (entry_uop),
        .entry_dst   (entry_dst),
        .issue_stall (issue_stall),
        .grant_valid (grant_valid),
        .grant_slot  (grant_slot),
        .issue_valid (issue_valid),
        .issue_slot  (issue_slot),
        .issue_uop   (issue_uop),
        .issue_dst   (issue_dst)
    );

endmodule

/* verif/tb_issue_queue.sv */
`timescale 1ns/1ps

module tb_issue_queue;

    localparam int    MAX_CYCLES  = 1000;
    localparam int    RESET_WAIT  = 20;
    localparam string GOLDEN_FILE = "verif/iq_golden.txt";

    logic               clk;
    logic               rst_n;

    logic               dispatch_valid;
    iq_pkg::uop_t       dispatch_uop;
    iq_pkg::preg_tag_t  dispatch_dst;
    iq_pkg::preg_tag_t  dispatch_src1;
    logic               dispatch_src1_ready;
    iq_pkg::preg_tag_t  dispatch_src2;
    logic               dispatch_src2_ready;
    logic               full;
    logic               wakeup_valid;
    iq_pkg::preg_tag_t  wakeup_tag;
    logic               issue_stall;
    logic               issue_valid;
    iq_pkg::slot_idx_t  issue_slot;
    iq_pkg::uop_t       issue_uop;
    iq_pkg::preg_tag_t  issue_dst;

    int                 errors;
    int                 checks;
    bit                 timed_out;

    issue_queue_top u_dut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .dispatch_valid      (dispatch_valid),
        .dispatch_uop        (dispatch_uop),
        .dispatch_dst        (dispatch_dst),
        .dispatch_src1       (dispatch_src1),
        .dispatch_src1_ready (dispatch_src1_ready),
        .dispatch_src2       (dispatch_src2),
        .dispatch_src2_ready (dispatch_src2_ready),
        .full                (full),
        .wakeup_valid        (wakeup_valid),
        .wakeup_tag          (wakeup_tag),
        .issue_stall         (issue_stall),
        .issue_valid         (issue_valid),
        .issue_slot          (issue_slot),
        .issue_uop           (issue_uop),
        .issue_dst           (issue_dst)
    );

    initial begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    // Reset held for four cycles and released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

    task automatic compare_field(input string test, input string field,
                                 input logic [15:0] expected, input logic [15:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error %s: %s expected %0h actual %0h", test, field, expected, actual);
        end
    endtask

    initial begin : replay
        int          fd;
        int          code;
        int          cycle;
        int          wait_cycles;
        bit          done;
        string       name;
        string       line;
        logic [15:0] f_dv;
        logic [15:0] f_uop;
        logic [15:0] f_dst;
        logic [15:0] f_src1;
        logic [15:0] f_rdy1;
        logic [15:0] f_src2;
        logic [15:0] f_rdy2;
        logic [15:0] f_wv;
        logic [15:0] f_wtag;
        logic [15:0] f_stall;
        logic [15:0] f_full;
        logic [15:0] f_iv;
        logic [15:0] f_slot;
        logic [15:0] f_iuop;
        logic [15:0] f_idst;

        dispatch_valid      = 1'b0;
        dispatch_uop        = '0;
        dispatch_dst        = '0;
        dispatch_src1       = '0;
        dispatch_src1_ready = 1'b0;
        dispatch_src2       = '0;
        dispatch_src2_ready = 1'b0;
        wakeup_valid        = 1'b0;
        wakeup_tag          = '0;
        issue_stall         = 1'b0;
        errors              = 0;
        checks              = 0;
        timed_out           = 1'b0;
        cycle               = 0;

        wait_cycles = 0;
        while (rst_n !== 1'b1 && wait_cycles < RESET_WAIT) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout: reset was not released after %0d cycles", RESET_WAIT);
            timed_out = 1'b1;
        end

        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", GOLDEN_FILE);
            errors++;
        end else begin
            done = 1'b0;
            while (!done && !timed_out) begin
                code = $fscanf(fd, "%s", name);
                if (code != 1) begin
                    done = 1'b1;
                end else if (name[0] == "#") begin
                    code = $fgets(line, fd);    // Rest of a comment line
                end else begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                   f_dv, f_uop, f_dst, f_src1, f_rdy1, f_src2, f_rdy2,
                                   f_wv, f_wtag, f_stall,
                                   f_full, f_iv, f_slot, f_iuop, f_idst);
                    if (code != 15) begin
                        $display("Vector line for test %s is malformed", name);
                        errors++;
                        done = 1'b1;
                    end else begin
                        @(posedge clk);
                        dispatch_valid      <= f_dv[0];
                        dispatch_uop        <= iq_pkg::uop_t'(f_uop);
                        dispatch_dst        <= iq_pkg::preg_tag_t'(f_dst);
                        dispatch_src1       <= iq_pkg::preg_tag_t'(f_src1);
                        dispatch_src1_ready <= f_rdy1[0];
                        dispatch_src2       <= iq_pkg::preg_tag_t'(f_src2);
                        dispatch_src2_ready <= f_rdy2[0];
                        wakeup_valid        <= f_wv[0];
                        wakeup_tag          <= iq_pkg::preg_tag_t'(f_wtag);
                        issue_stall         <= f_stall[0];

                        // Outputs reflect the state left by the previous line
                        @(negedge clk);
                        compare_field(name, "full", f_full, 16'(full));
                        compare_field(name, "issue_valid", f_iv, 16'(issue_valid));
                        if (f_iv[0]) begin
                            compare_field(name, "issue_slot", f_slot, 16'(issue_slot));
                            compare_field(name, "issue_uop", f_iuop, 16'(issue_uop));
                            compare_field(name, "issue_dst", f_idst, 16'(issue_dst));
                        end

                        cycle++;
                        if (cycle >= MAX_CYCLES) begin
                            $display("Timeout: vector replay ran past %0d cycles", MAX_CYCLES);
                            timed_out = 1'b1;
                        end
                    end
                end
            end
            $fclose(fd);
            if (cycle == 0 && !timed_out) begin
                $display("The vector file held no stimulus lines");
                errors++;
            end
        end

        $display("Cycles: %0d, checks: %0d, errors: %0d", cycle, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* verif/iq_golden.txt */
# name dv uop dst src1 rdy1 src2 rdy2 wv wtag stall | full iv slot iuop idst (all hex)
# Expected columns are the outputs seen during the cycle these inputs are applied
alloc_s0          1 1100 20 01 0 02 0 0 00 0  0 0 0 0000 00
alloc_s1          1 1101 21 03 0 04 0 0 00 0  0 0 0 0000 00
alloc_s2          1 1102 22 05 0 06 0 0 00 0  0 0 0 0000 00
alloc_s3          1 1103 23 07 0 08 0 0 00 0  0 0 0 0000 00
alloc_s4          1 1104 24 09 0 0a 0 0 00 0  0 0 0 0000 00
alloc_s5          1 1105 25 0b 0 0c 0 0 00 0  0 0 0 0000 00
alloc_s6          1 1106 26 0d 0 0e 0 0 00 0  0 0 0 0000 00
alloc_s7          1 1107 27 0f 0 10 0 0 00 0  0 0 0 0000 00
alloc_full_drop   1 11ff 3f 01 1 02 1 0 00 0  1 0 0 0000 00
wake_nomatch      0 0000 00 00 0 00 0 1 3e 0  1 0 0 0000 00
wake_s0_src1      0 0000 00 00 0 00 0 1 01 0  1 0 0 0000 00
wake_s0_src2      0 0000 00 00 0 00 0 1 02 0  1 0 0 0000 00
wake_s1_src2      0 0000 00 00 0 00 0 1 04 0  1 0 0 0000 00
reuse_s0          1 2200 30 11 0 12 0 1 03 0  0 1 0 1100 20
issue_s1          0 0000 00 00 0 00 0 0 00 0  1 0 0 0000 00
ready_dispatch    1 2201 31 13 1 14 1 0 00 0  0 1 1 1101 21
wake_s2_src1      0 0000 00 00 0 00 0 1 05 0  1 0 0 0000 00
wake_s2_src2      0 0000 00 00 0 00 0 1 06 0  0 1 1 2201 31
stall_wake_a      0 0000 00 00 0 00 0 1 07 1  0 0 0 0000 00
stall_wake_b      0 0000 00 00 0 00 0 1 08 1  0 0 0 0000 00
stall_wake_c      0 0000 00 00 0 00 0 1 09 1  0 0 0 0000 00
stall_wake_d      0 0000 00 00 0 00 0 1 0a 1  0 0 0 0000 00
stall_hold        0 0000 00 00 0 00 0 0 00 1  0 0 0 0000 00
stall_release     0 0000 00 00 0 00 0 0 00 0  0 0 0 0000 00
prio_s4           0 0000 00 00 0 00 0 0 00 0  0 1 4 1104 24
prio_s3           0 0000 00 00 0 00 0 0 00 0  0 1 3 1103 23
disp_wake_src1    1 3300 32 0b 0 15 1 1 0b 0  0 1 2 1102 22
disp_wake_src2    1 3301 33 16 0 0c 0 1 0c 0  0 0 0 0000 00
wake_disp_other   0 0000 00 00 0 00 0 1 16 0  0 1 1 3300 32
issue_s5          0 0000 00 00 0 00 0 0 00 0  0 1 5 1105 25
shared_tag_a      1 4400 34 2a 0 17 1 0 00 0  0 1 2 3301 33
shared_tag_b      1 4401 35 2a 0 18 1 0 00 0  0 0 0 0000 00
shared_tag_c      1 4402 36 2a 0 19 1 0 00 0  0 0 0 0000 00
wake_shared       0 0000 00 00 0 00 0 1 2a 0  0 0 0 0000 00
shared_ready      0 0000 00 00 0 00 0 0 00 0  0 0 0 0000 00
shared_issue_s3   0 0000 00 00 0 00 0 0 00 0  0 1 3 4402 36
stall_mid_issue   0 0000 00 00 0 00 0 1 0d 1  0 1 2 4401 35
stall_drop_valid  0 0000 00 00 0 00 0 1 0e 1  0 0 0 0000 00
stall_resume      0 0000 00 00 0 00 0 1 0f 0  0 0 0 0000 00
resume_s6         0 0000 00 00 0 00 0 1 10 0  0 1 6 1106 26
resume_s1         0 0000 00 00 0 00 0 0 00 0  0 1 1 4400 34
refill_s1         1 5501 01 3a 0 3b 0 0 00 0  0 1 7 1107 27
refill_s2         1 5502 02 3a 0 3b 0 0 00 0  0 0 0 0000 00
refill_s3         1 5503 03 3a 0 3b 0 0 00 0  0 0 0 0000 00
refill_s4         1 5504 04 3a 0 3b 0 0 00 0  0 0 0 0000 00
refill_s5         1 5505 05 3a 0 3b 0 0 00 0  0 0 0 0000 00
refill_s6         1 5506 06 3a 0 3b 0 0 00 0  0 0 0 0000 00
refill_s7         1 5507 07 3a 0 3b 0 0 00 0  0 0 0 0000 00
refill_full_drop  1 5fff 3f 3c 1 3d 1 0 00 0  1 0 0 0000 00
wake_s0_late1     0 0000 00 00 0 00 0 1 11 0  1 0 0 0000 00
wake_s0_late2     0 0000 00 00 0 00 0 1 12 0  1 0 0 0000 00
wake_refill_src1  0 0000 00 00 0 00 0 1 3a 0  1 0 0 0000 00
reuse_wake_disp   1 6600 2f 3b 0 3e 1 1 3b 0  0 1 0 2200 30
full_again        0 0000 00 00 0 00 0 0 00 0  1 0 0 0000 00
drain_s7          0 0000 00 00 0 00 0 0 00 0  0 1 7 5507 07
drain_s6          0 0000 00 00 0 00 0 0 00 0  0 1 6 5506 06
drain_s5          0 0000 00 00 0 00 0 0 00 0  0 1 5 5505 05
drain_s4          0 0000 00 00 0 00 0 0 00 0  0 1 4 5504 04
drain_s3          0 0000 00 00 0 00 0 0 00 0  0 1 3 5503 03
drain_s2          0 0000 00 00 0 00 0 0 00 0  0 1 2 5502 02
drain_s1          0 0000 00 00 0 00 0 0 00 0  0 1 1 5501 01
drain_s0          0 0000 00 00 0 00 0 0 00 0  0 1 0 6600 2f
final_idle        0 0000 00 00 0 00 0 0 00 0  0 0 0 0000 00

/* flist.f */
common/iq_pkg.sv
src/pick1_priority_bin.sv
issue_queue/iq_entry_array.sv
issue_queue/iq_select.sv
src/issue_queue_top.sv
verif/tb_issue_queue.sv
